/* flist.f */
+incdir+source
+incdir+tb
source/rvvi_trace_pkg.sv
source/retire_stage.sv
source/csr_track.sv
source/gpr_track.sv
source/fault_net_tracker.sv
source/rvvi_trace_top.sv
tb/tb_rvvi_trace.sv

/* source/csr_track.sv */
// CSR reconstruction for the tracked machine CSR lanes
// Masked merge of written and read values, per-lane writeback flags
// Lanes follow CSR_LANE_MSTATUS through CSR_LANE_MCAUSE

`timescale 1ns/10ps
`include "rvvi_settings.svh"

module csr_track
   import rvvi_trace_pkg::*;
(
   input  logic            rvvi,
   input  logic            rst_n_i,
   input  logic            retire_accept_i,
   input  csr_word_array_t csr_rdata_i,
   input  csr_word_array_t csr_wdata_i,
   input  csr_word_array_t csr_wmask_i,
   input  csr_word_array_t csr_rmask_i,
   output csr_word_array_t csr_value_o,
   output csr_flag_t       csr_wb_o
);

   csr_word_array_t merged;
   csr_flag_t       touched;

   //////////////////////////////////////////////////
   // Merge
   //////////////////////////////////////////////////

   // Written bits under the write mask, read bits elsewhere
   always_comb begin
      for (int lane = 0; lane < `RVVI_NUM_CSR; lane++) begin
         merged[lane]  = (csr_wdata_i[lane] & csr_wmask_i[lane]) |
                         (csr_rdata_i[lane] & ~csr_wmask_i[lane]);
         touched[lane] = (|csr_wmask_i[lane]) || (|csr_rmask_i[lane]);
      end
   end

   //////////////////////////////////////////////////
   // Lane registers
   //////////////////////////////////////////////////

   always_ff @(posedge rvvi) begin
      if (!rst_n_i) begin
         csr_value_o <= '0;
         csr_wb_o    <= '0;
      end else begin
         // wb is a one-cycle flag
         csr_wb_o <= '0;
         if (retire_accept_i) begin
            // Every lane takes the merge on an accept
            csr_wb_o    <= touched;
            csr_value_o <= merged;
         end
      end
   end

   // A writeback flag always follows an accepted record
   a_wb_after_accept: assert property (@(posedge rvvi) disable iff (!rst_n_i)
      (|csr_wb_o) |-> $past(retire_accept_i));

endmodule

/* source/fault_net_tracker.sv */
// Net events derived from retirement records
// Load/store NMI level, cause and change pulses
// Instruction-bus fault level and change pulse

`timescale 1ns/10ps
`include "rvvi_settings.svh"

module fault_net_tracker
   import rvvi_trace_pkg::*;
(
   input  logic        rvvi,
   input  logic        rst_n_i,
   input  logic        retire_accept_i,
   input  trap_info_t  rvfi_trap_i,
   input  intr_info_t  rvfi_intr_i,
   input  logic [1:0]  rvfi_nmip_i,
   output logic        nmi_o,
   output logic        nmi_change_o,
   output intr_cause_t nmi_cause_o,
   output logic        nmi_cause_change_o,
   output logic        ifetch_fault_o,
   output logic        ifetch_fault_change_o
);

   logic nmi_cause_hit;
   logic nmi_cond;
   logic ifetch_cond;

   assign nmi_cause_hit = rvfi_intr_i.cause == intr_cause_t'(`NMI_CAUSE_LOAD) ||
                          rvfi_intr_i.cause == intr_cause_t'(`NMI_CAUSE_STORE);
   // Taken NMI, or one still pending (nmip bit 0)
   assign nmi_cond      = (rvfi_intr_i.intr && rvfi_intr_i.interrupt && nmi_cause_hit) ||
                          rvfi_nmip_i[0];
   assign ifetch_cond   = rvfi_trap_i.trap && rvfi_trap_i.exception &&
                          rvfi_trap_i.exception_cause == 6'(`EXC_CAUSE_INSTR_BUS_FAULT);

   always_ff @(posedge rvvi) begin
      if (!rst_n_i) begin
         nmi_o                 <= 1'b0;
         nmi_change_o          <= 1'b0;
         nmi_cause_o           <= '0;
         nmi_cause_change_o    <= 1'b0;
         ifetch_fault_o        <= 1'b0;
         ifetch_fault_change_o <= 1'b0;
      end else begin
         // Pulses by default, levels hold
         nmi_change_o          <= 1'b0;
         nmi_cause_change_o    <= 1'b0;
         ifetch_fault_change_o <= 1'b0;
         if (retire_accept_i) begin
            nmi_o                 <= nmi_cond;
            nmi_change_o          <= nmi_cond != nmi_o;
            ifetch_fault_o        <= ifetch_cond;
            ifetch_fault_change_o <= ifetch_cond != ifetch_fault_o;
            if (nmi_cond) begin
               nmi_cause_o        <= rvfi_intr_i.cause;
               nmi_cause_change_o <= rvfi_intr_i.cause != nmi_cause_o;
            end
         end
      end
   end

   // Pulses line up with a real change of the level
   a_nmi_change: assert property (@(posedge rvvi) disable iff (!rst_n_i)
      nmi_change_o |-> nmi_o != $past(nmi_o));
   a_ifetch_change: assert property (@(posedge rvvi) disable iff (!rst_n_i)
      ifetch_fault_change_o |-> ifetch_fault_o != $past(ifetch_fault_o));

endmodule

/* source/gpr_track.sv */
// General register write capture
// Written words and write mask of the last accepted record, x0 never reported

`timescale 1ns/10ps
`include "rvvi_settings.svh"

module gpr_track
   import rvvi_trace_pkg::*;
(
   input  logic            rvvi,
   input  logic            rst_n_i,
   input  logic            retire_accept_i,
   input  gpr_word_array_t gpr_wdata_i,
   input  gpr_mask_t       gpr_wmask_i,
   output gpr_word_array_t x_wdata_o,
   output gpr_mask_t       x_wb_o
);

   logic gpr_write;

   // Writes to x0 alone do not count
   assign gpr_write = retire_accept_i && (|gpr_wmask_i[`RVVI_NUM_GPR-1:1]);

   always_ff @(posedge rvvi) begin
      if (!rst_n_i) begin
         x_wdata_o <= '0;
         x_wb_o    <= '0;
      end else if (gpr_write) begin
         x_wb_o <= {gpr_wmask_i[`RVVI_NUM_GPR-1:1], 1'b0};
         for (int r = 1; r < `RVVI_NUM_GPR; r++) begin
            // Unwritten registers read back as zero
            x_wdata_o[r] <= gpr_wmask_i[r] ? gpr_wdata_i[r] : '0;
         end
      end else begin
         x_wb_o <= '0;
      end
   end

   // Flags only after an accept, and never for x0
   a_wb_no_x0: assert property (@(posedge rvvi) disable iff (!rst_n_i)
      (|x_wb_o) |-> ($past(retire_accept_i) && !x_wb_o[0]));

endmodule

/* source/retire_stage.sv */
// Retirement stage
// Order deduplication and accept strobe, trap filter,
// registered instruction, PC, mode and privilege width

`timescale 1ns/10ps
`include "rvvi_settings.svh"

module retire_stage
   import rvvi_trace_pkg::*;
(
   input  logic       rvvi,
   input  logic       rst_n_i,
   input  logic       rvfi_valid_i,
   input  order_t     rvfi_order_i,
   input  xlen_t      rvfi_insn_i,
   input  xlen_t      rvfi_pc_rdata_i,
   input  xlen_t      rvfi_pc_wdata_i,
   input  logic [1:0] rvfi_mode_i,
   input  logic [1:0] rvfi_ixl_i,
   input  trap_info_t rvfi_trap_i,
   input  intr_info_t rvfi_intr_i,
   output logic       retire_accept_o,
   output logic       valid_o,
   output order_t     order_o,
   output xlen_t      insn_o,
   output xlen_t      pc_rdata_o,
   output xlen_t      pc_wdata_o,
   output logic [1:0] mode_o,
   output logic [1:0] ixl_o,
   output logic       trap_o,
   output logic       intr_o
);

   order_t last_order_q;
   logic   order_seen_q;
   logic   dbg_no_retire;
   logic   trap_filt;

   // First record after reset has nothing to compare against
   assign retire_accept_o = rvfi_valid_i && (!order_seen_q || rvfi_order_i != last_order_q);

   // Ebreak and trigger entries into debug never retire
   assign dbg_no_retire = rvfi_trap_i.debug &&
                          (rvfi_trap_i.debug_cause == 3'(`DBG_CAUSE_EBREAK) ||
                           rvfi_trap_i.debug_cause == 3'(`DBG_CAUSE_TRIGGER));
   assign trap_filt     = rvfi_trap_i.trap && (rvfi_trap_i.exception || dbg_no_retire);

   always_ff @(posedge rvvi) begin
      if (!rst_n_i) begin
         order_seen_q <= 1'b0;
         last_order_q <= '0;
         valid_o      <= 1'b0;
         order_o      <= '0;
         insn_o       <= '0;
         pc_rdata_o   <= '0;
         pc_wdata_o   <= '0;
         mode_o       <= '0;
         ixl_o        <= '0;
         trap_o       <= 1'b0;
         intr_o       <= 1'b0;
      end else begin
         valid_o <= retire_accept_o;
         if (retire_accept_o) begin
            order_seen_q <= 1'b1;
            last_order_q <= rvfi_order_i;
            order_o      <= rvfi_order_i;
            insn_o       <= rvfi_insn_i;
            pc_rdata_o   <= rvfi_pc_rdata_i;
            pc_wdata_o   <= rvfi_pc_wdata_i;
            mode_o       <= rvfi_mode_i;
            ixl_o        <= rvfi_ixl_i;
            trap_o       <= trap_filt;
            intr_o       <= rvfi_intr_i.intr;
         end
      end
   end

   // No record is reported twice in a row
   a_no_repeat_order: assert property (@(posedge rvvi) disable iff (!rst_n_i)
      valid_o |=> !(valid_o && $stable(order_o)));

endmodule

/* source/rvvi_settings.svh */
// Widths and counts for the retirement trace converter
// CSR lane indices, NMI and fetch-fault causes, debug causes

`ifndef RVVI_SETTINGS_SVH
`define RVVI_SETTINGS_SVH

`define RVVI_XLEN                  32
`define RVVI_NUM_GPR               32
`define RVVI_ORDER_W               64

// Tracked machine CSR lanes
`define RVVI_NUM_CSR               6
`define CSR_LANE_MSTATUS           0
`define CSR_LANE_MIE               1
`define CSR_LANE_MTVEC             2
`define CSR_LANE_MSCRATCH          3
`define CSR_LANE_MEPC              4
`define CSR_LANE_MCAUSE            5

`define NMI_CAUSE_LOAD             1024
`define NMI_CAUSE_STORE            1025
`define EXC_CAUSE_INSTR_BUS_FAULT  24
`define DBG_CAUSE_EBREAK           1
`define DBG_CAUSE_TRIGGER          2

`endif

/* source/rvvi_trace_pkg.sv */
// Shared data types of the retirement trace converter
// Trap and interrupt records, CSR and GPR arrays

`include "rvvi_settings.svh"

package rvvi_trace_pkg;

   typedef logic [`RVVI_XLEN-1:0]    xlen_t;
   typedef logic [`RVVI_ORDER_W-1:0] order_t;

   // Trap record as it comes out of the core, 12 bits
   typedef struct packed {
      logic       trap;
      logic       exception;
      logic       debug;
      logic [5:0] exception_cause;
      logic [2:0] debug_cause;
   } trap_info_t;

   typedef logic [10:0] intr_cause_t;

   // Interrupt record, 14 bits
   typedef struct packed {
      logic        intr;
      logic        exception;
      logic        interrupt;
      intr_cause_t cause;
   } intr_info_t;

   typedef xlen_t [`RVVI_NUM_CSR-1:0] csr_word_array_t;
   typedef logic  [`RVVI_NUM_CSR-1:0] csr_flag_t;
   typedef xlen_t [`RVVI_NUM_GPR-1:0] gpr_word_array_t;
   typedef logic  [`RVVI_NUM_GPR-1:0] gpr_mask_t;

endpackage

/* source/rvvi_trace_top.sv */
// Retirement trace to verification trace converter, top level
// Retire stage, CSR and GPR tracking, fault net events

`timescale 1ns/10ps
`include "rvvi_settings.svh"

module rvvi_trace_top
   import rvvi_trace_pkg::*;
(
   input  logic            rvvi,
   input  logic            rst_n_i,
   input  logic            rvfi_valid_i,
   input  order_t          rvfi_order_i,
   input  xlen_t           rvfi_insn_i,
   input  xlen_t           rvfi_pc_rdata_i,
   input  xlen_t           rvfi_pc_wdata_i,
   input  logic [1:0]      rvfi_mode_i,
   input  logic [1:0]      rvfi_ixl_i,
   input  trap_info_t      rvfi_trap_i,
   input  intr_info_t      rvfi_intr_i,
   input  logic [1:0]      rvfi_nmip_i,
   input  csr_word_array_t csr_rdata_i,
   input  csr_word_array_t csr_wdata_i,
   input  csr_word_array_t csr_wmask_i,
   input  csr_word_array_t csr_rmask_i,
   input  gpr_word_array_t gpr_wdata_i,
   input  gpr_mask_t       gpr_wmask_i,
   output logic            valid_o,
   output order_t          order_o,
   output xlen_t           insn_o,
   output xlen_t           pc_rdata_o,
   output xlen_t           pc_wdata_o,
   output logic [1:0]      mode_o,
   output logic [1:0]      ixl_o,
   output logic            trap_o,
   output logic            intr_o,
   output csr_word_array_t csr_value_o,
   output csr_flag_t       csr_wb_o,
   output gpr_word_array_t x_wdata_o,
   output gpr_mask_t       x_wb_o,
   output logic            nmi_o,
   output logic            nmi_change_o,
   output intr_cause_t     nmi_cause_o,
   output logic            nmi_cause_change_o,
   output logic            ifetch_fault_o,
   output logic            ifetch_fault_change_o
);

   // One strobe per new order, shared by all trackers
   logic retire_accept;

   retire_stage retire_stage_i (
      .rvvi            (rvvi),
      .rst_n_i         (rst_n_i),
      .rvfi_valid_i    (rvfi_valid_i),
      .rvfi_order_i    (rvfi_order_i),
      .rvfi_insn_i     (rvfi_insn_i),
      .rvfi_pc_rdata_i (rvfi_pc_rdata_i),
      .rvfi_pc_wdata_i (rvfi_pc_wdata_i),
      .rvfi_mode_i     (rvfi_mode_i),
      .rvfi_ixl_i      (rvfi_ixl_i),
      .rvfi_trap_i     (rvfi_trap_i),
      .rvfi_intr_i     (rvfi_intr_i),
      .retire_accept_o (retire_accept),
      .valid_o         (valid_o),
      .order_o         (order_o),
      .insn_o          (insn_o),
      .pc_rdata_o      (pc_rdata_o),
      .pc_wdata_o      (pc_wdata_o),
      .mode_o          (mode_o),
      .ixl_o           (ixl_o),
      .trap_o          (trap_o),
      .intr_o          (intr_o)
   );

   csr_track csr_track_i (
      .rvvi            (rvvi),
      .rst_n_i         (rst_n_i),
      .retire_accept_i (retire_accept),
      .csr_rdata_i     (csr_rdata_i),
      .csr_wdata_i     (csr_wdata_i),
      .csr_wmask_i     (csr_wmask_i),
      .csr_rmask_i     (csr_rmask_i),
      .csr_value_o     (csr_value_o),
      .csr_wb_o        (csr_wb_o)
   );

   gpr_track gpr_track_i (
      .rvvi            (rvvi),
      .rst_n_i         (rst_n_i),
      .retire_accept_i (retire_accept),
      .gpr_wdata_i     (gpr_wdata_i),
      .gpr_wmask_i     (gpr_wmask_i),
      .x_wdata_o       (x_wdata_o),
      .x_wb_o          (x_wb_o)
   );

   fault_net_tracker fault_net_tracker_i (
      .rvvi                  (rvvi),
      .rst_n_i               (rst_n_i),
      .retire_accept_i       (retire_accept),
      .rvfi_trap_i           (rvfi_trap_i),
      .rvfi_intr_i           (rvfi_intr_i),
      .rvfi_nmip_i           (rvfi_nmip_i),
      .nmi_o                 (nmi_o),
      .nmi_change_o          (nmi_change_o),
      .nmi_cause_o           (nmi_cause_o),
      .nmi_cause_change_o    (nmi_cause_change_o),
      .ifetch_fault_o        (ifetch_fault_o),
      .ifetch_fault_change_o (ifetch_fault_change_o)
   );

endmodule

/* tb/tb_vectors.svh */
// Stimulus and expected-value table of retirement records
// Inputs: name, valid, order, trap record, interrupt record, nmip,
//         CSR write lanes, CSR read lanes, GPR write mask
// Expected: valid, trap, nmi, nmi change, nmi cause, cause change,
//           fetch fault, fetch fault change

task automatic load_vectors();
   // Reset state seen through an idle cycle
   add_row("reset_idle", 0, 0, trap_rec(0, 0, 0, 0, 0), intr_rec(0, 0, 0),
           0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
   add_row("plain_retire", 1, 1, trap_rec(0, 0, 0, 0, 0), intr_rec(0, 0, 0),
           0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0);
   // Trap filter
   add_row("trap_exception", 1, 2, trap_rec(1, 1, 0, 2, 0), intr_rec(0, 0, 0),
           0, 0, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0);
   add_row("trap_dbg_ebreak", 1, 3, trap_rec(1, 0, 1, 0, `DBG_CAUSE_EBREAK), intr_rec(0, 0, 0),
           0, 0, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0);
   add_row("trap_dbg_trigger", 1, 4, trap_rec(1, 0, 1, 0, `DBG_CAUSE_TRIGGER), intr_rec(0, 0, 0),
           0, 0, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0);
   add_row("trap_dbg_cause3", 1, 5, trap_rec(1, 0, 1, 0, 3), intr_rec(0, 0, 0),
           0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0);
   add_row("trap_none", 1, 6, trap_rec(0, 0, 0, 0, 0), intr_rec(0, 0, 0),
           0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0);
   // CSR merge, all lanes written, then two lanes read only
   add_row("csr_merge_all", 1, 7, trap_rec(0, 0, 0, 0, 0), intr_rec(0, 0, 0),
           0, 6'h3F, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0);
   add_row("csr_read_only", 1, 8, trap_rec(0, 0, 0, 0, 0), intr_rec(0, 0, 0),
           0, 0, (6'd1 << `CSR_LANE_MSTATUS) | (6'd1 << `CSR_LANE_MTVEC), 0,
           1, 0, 0, 0, 0, 0, 0, 0);
   // Repeated order with pending NMI, every tracker must hold
   add_row("order_repeat", 1, 8, trap_rec(0, 0, 0, 0, 0), intr_rec(0, 0, 0),
           1, 6'h3F, 0, 32'h20, 0, 0, 0, 0, 0, 0, 0, 0);
   // GPR capture
   add_row("gpr_x0_x5", 1, 9, trap_rec(0, 0, 0, 0, 0), intr_rec(0, 0, 0),
           0, 0, 0, 32'h21, 1, 0, 0, 0, 0, 0, 0, 0);
   add_row("gpr_none", 1, 10, trap_rec(0, 0, 0, 0, 0), intr_rec(0, 0, 0),
           0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0);
   // NMI sequence
   add_row("nmi_load", 1, 11, trap_rec(0, 0, 0, 0, 0), intr_rec(1, 1, `NMI_CAUSE_LOAD),
           0, 0, 0, 0, 1, 0, 1, 1, `NMI_CAUSE_LOAD, 1, 0, 0);
   add_row("nmi_load_again", 1, 12, trap_rec(0, 0, 0, 0, 0), intr_rec(1, 1, `NMI_CAUSE_LOAD),
           0, 0, 0, 0, 1, 0, 1, 0, `NMI_CAUSE_LOAD, 0, 0, 0);
   add_row("nmi_store", 1, 13, trap_rec(0, 0, 0, 0, 0), intr_rec(1, 1, `NMI_CAUSE_STORE),
           0, 0, 0, 0, 1, 0, 1, 0, `NMI_CAUSE_STORE, 1, 0, 0);
   add_row("nmi_clear", 1, 14, trap_rec(0, 0, 0, 0, 0), intr_rec(0, 0, 0),
           0, 0, 0, 0, 1, 0, 0, 1, `NMI_CAUSE_STORE, 0, 0, 0);
   // Instruction-bus fault sequence
   add_row("ifetch_fault", 1, 15, trap_rec(1, 1, 0, `EXC_CAUSE_INSTR_BUS_FAULT, 0),
           intr_rec(0, 0, 0), 0, 0, 0, 0, 1, 1, 0, 0, `NMI_CAUSE_STORE, 0, 1, 1);
   add_row("ifetch_fault_again", 1, 16, trap_rec(1, 1, 0, `EXC_CAUSE_INSTR_BUS_FAULT, 0),
           intr_rec(0, 0, 0), 0, 0, 0, 0, 1, 1, 0, 0, `NMI_CAUSE_STORE, 0, 1, 0);
   add_row("ifetch_clear", 1, 17, trap_rec(0, 0, 0, 0, 0), intr_rec(0, 0, 0),
           0, 0, 0, 0, 1, 0, 0, 0, `NMI_CAUSE_STORE, 0, 0, 1);
   add_row("idle_end", 0, 18, trap_rec(0, 0, 0, 0, 0), intr_rec(0, 0, 0),
           0, 0, 0, 0, 0, 0, 0, 0, `NMI_CAUSE_STORE, 0, 0, 0);
endtask

/* tb/tb_rvvi_trace.sv */
// Testbench for the retirement trace converter
// Clock and reset, table-driven stimulus, reference model,
// immediate checks, watchdog and summary

`timescale 1ns/10ps
`include "rvvi_settings.svh"

module tb_rvvi_trace
   import rvvi_trace_pkg::*;
();

   localparam int CLK_PERIOD = 8;
   localparam int RST_CYCLES = 8;
   localparam logic [31:0] SEED = 32'h7a8448ba;

   logic rvvi = 1'b0;
   logic rst_n_i;
   logic rvfi_valid_i;
   order_t rvfi_order_i;
   xlen_t rvfi_insn_i, rvfi_pc_rdata_i, rvfi_pc_wdata_i;
   logic [1:0] rvfi_mode_i, rvfi_ixl_i, rvfi_nmip_i;
   trap_info_t rvfi_trap_i;
   intr_info_t rvfi_intr_i;
   csr_word_array_t csr_rdata_i, csr_wdata_i, csr_wmask_i, csr_rmask_i, csr_value_o;
   gpr_word_array_t gpr_wdata_i, x_wdata_o;
   gpr_mask_t gpr_wmask_i, x_wb_o;
   logic valid_o, trap_o, intr_o;
   order_t order_o;
   xlen_t insn_o, pc_rdata_o, pc_wdata_o;
   logic [1:0] mode_o, ixl_o;
   csr_flag_t csr_wb_o;
   logic nmi_o, nmi_change_o, nmi_cause_change_o, ifetch_fault_o, ifetch_fault_change_o;
   intr_cause_t nmi_cause_o;

   // Table columns
   string name_q[$];
   logic valid_q[$];
   order_t order_q[$];
   trap_info_t trap_q[$];
   intr_info_t intr_q[$];
   logic [1:0] nmip_q[$];
   csr_flag_t wsel_q[$], rsel_q[$];
   gpr_mask_t gmask_q[$];
   logic [6:0] exp_q[$];
   intr_cause_t cause_q[$];

   // Reference model state
   order_t exp_order;
   xlen_t exp_insn, exp_pc_rdata, exp_pc_wdata;
   logic [1:0] exp_mode, exp_ixl;
   logic exp_intr;
   csr_word_array_t csr_model;
   csr_flag_t exp_csr_wb;
   gpr_word_array_t gpr_model;
   gpr_mask_t exp_x_wb;

   string cur_name;
   int row_errors, pass_count, fail_count;

   rvvi_trace_top rvvi_trace_top_i (.*);

   always #(CLK_PERIOD / 2) rvvi = ~rvvi;

   function automatic trap_info_t trap_rec(input logic t, input logic e, input logic d,
                                           input logic [5:0] ec, input logic [2:0] dc);
      return '{trap: t, exception: e, debug: d, exception_cause: ec, debug_cause: dc};
   endfunction

   function automatic intr_info_t intr_rec(input logic in, input logic it, input intr_cause_t c);
      return '{intr: in, exception: 1'b0, interrupt: it, cause: c};
   endfunction

   task automatic add_row(input string name, input logic valid, input order_t order,
                          input trap_info_t trap, input intr_info_t intr, input logic [1:0] nmip,
                          input csr_flag_t wsel, input csr_flag_t rsel, input gpr_mask_t gmask,
                          input logic e_valid, input logic e_trap, input logic e_nmi,
                          input logic e_nmi_chg, input intr_cause_t e_cause,
                          input logic e_cause_chg, input logic e_if, input logic e_if_chg);
      name_q.push_back(name);
      valid_q.push_back(valid);
      order_q.push_back(order);
      trap_q.push_back(trap);
      intr_q.push_back(intr);
      nmip_q.push_back(nmip);
      wsel_q.push_back(wsel);
      rsel_q.push_back(rsel);
      gmask_q.push_back(gmask);
      exp_q.push_back({e_valid, e_trap, e_nmi, e_nmi_chg, e_cause_chg, e_if, e_if_chg});
      cause_q.push_back(e_cause);
   endtask

   `include "tb_vectors.svh"

   //////////////////////////////////////////////////
   // Stimulus and reference model
   //////////////////////////////////////////////////

   task automatic drive_row(input int i);
      rvfi_valid_i    = valid_q[i];
      rvfi_order_i    = order_q[i];
      rvfi_trap_i     = trap_q[i];
      rvfi_intr_i     = intr_q[i];
      rvfi_nmip_i     = nmip_q[i];
      rvfi_insn_i     = $urandom;
      rvfi_pc_rdata_i = $urandom;
      rvfi_pc_wdata_i = $urandom;
      rvfi_mode_i     = 2'($urandom);
      rvfi_ixl_i      = 2'($urandom);
      for (int l = 0; l < `RVVI_NUM_CSR; l++) begin
         csr_rdata_i[l] = $urandom;
         csr_wdata_i[l] = $urandom;
         csr_wmask_i[l] = wsel_q[i][l] ? xlen_t'($urandom) : '0;
         csr_rmask_i[l] = rsel_q[i][l] ? '1 : '0;
      end
      for (int r = 0; r < `RVVI_NUM_GPR; r++) begin
         gpr_wdata_i[r] = $urandom;
      end
      gpr_wmask_i = gmask_q[i];
   endtask

   // Expected state one edge after the driven record
   task automatic predict_row(input int i);
      exp_csr_wb = '0;
      exp_x_wb   = '0;
      if (exp_q[i][6]) begin
         exp_order    = rvfi_order_i;
         exp_insn     = rvfi_insn_i;
         exp_pc_rdata = rvfi_pc_rdata_i;
         exp_pc_wdata = rvfi_pc_wdata_i;
         exp_mode     = rvfi_mode_i;
         exp_ixl      = rvfi_ixl_i;
         exp_intr     = rvfi_intr_i.intr;
         for (int l = 0; l < `RVVI_NUM_CSR; l++) begin
            exp_csr_wb[l] = (csr_wmask_i[l] != 0) || (csr_rmask_i[l] != 0);
            // Bit by bit, written data where the write mask is set
            for (int b = 0; b < `RVVI_XLEN; b++) begin
               csr_model[l][b] = csr_wmask_i[l][b] ? csr_wdata_i[l][b]
                                                   : csr_rdata_i[l][b];
            end
         end
         // x0 is never reported
         if (gpr_wmask_i[`RVVI_NUM_GPR-1:1] != 0) begin
            exp_x_wb    = gpr_wmask_i;
            exp_x_wb[0] = 1'b0;
            for (int r = 1; r < `RVVI_NUM_GPR; r++) begin
               gpr_model[r] = gpr_wmask_i[r] ? gpr_wdata_i[r] : '0;
            end
         end
      end
   endtask

   //////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////

   task automatic check_value(input string field, input logic [63:0] exp_v,
                              input logic [63:0] act_v);
      assert (act_v === exp_v) else begin
         $display("MISMATCH %s %s expected %0h actual %0h", cur_name, field, exp_v, act_v);
         row_errors++;
      end
   endtask

   task automatic check_row(input int i);
      logic [6:0] f;
      f = exp_q[i];
      check_value("valid", f[6], valid_o);
      check_value("order", exp_order, order_o);
      check_value("insn", exp_insn, insn_o);
      check_value("pc_rdata", exp_pc_rdata, pc_rdata_o);
      check_value("pc_wdata", exp_pc_wdata, pc_wdata_o);
      check_value("mode", exp_mode, mode_o);
      check_value("ixl", exp_ixl, ixl_o);
      check_value("intr", exp_intr, intr_o);
      check_value("trap", f[5], trap_o);
      for (int l = 0; l < `RVVI_NUM_CSR; l++) begin
         check_value($sformatf("csr_value[%0d]", l), csr_model[l], csr_value_o[l]);
      end
      check_value("csr_wb", exp_csr_wb, csr_wb_o);
      for (int r = 0; r < `RVVI_NUM_GPR; r++) begin
         check_value($sformatf("x_wdata[%0d]", r), gpr_model[r], x_wdata_o[r]);
      end
      check_value("x_wb", exp_x_wb, x_wb_o);
      check_value("nmi", f[4], nmi_o);
      check_value("nmi_change", f[3], nmi_change_o);
      check_value("nmi_cause", cause_q[i], nmi_cause_o);
      check_value("nmi_cause_change", f[2], nmi_cause_change_o);
      check_value("ifetch_fault", f[1], ifetch_fault_o);
      check_value("ifetch_fault_change", f[0], ifetch_fault_change_o);
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial begin
      rst_n_i = 1'b0;
      rvfi_valid_i = 1'b0;
      rvfi_order_i = '0;
      rvfi_insn_i = '0;
      rvfi_pc_rdata_i = '0;
      rvfi_pc_wdata_i = '0;
      rvfi_mode_i = '0;
      rvfi_ixl_i = '0;
      rvfi_nmip_i = '0;
      rvfi_trap_i = '0;
      rvfi_intr_i = '0;
      csr_rdata_i = '0;
      csr_wdata_i = '0;
      csr_wmask_i = '0;
      csr_rmask_i = '0;
      gpr_wdata_i = '0;
      gpr_wmask_i = '0;
      exp_order = '0;
      exp_insn = '0;
      exp_pc_rdata = '0;
      exp_pc_wdata = '0;
      exp_mode = '0;
      exp_ixl = '0;
      exp_intr = 1'b0;
      csr_model = '0;
      gpr_model = '0;
      pass_count = 0;
      fail_count = 0;
      void'($urandom(SEED));
      load_vectors();

      repeat (RST_CYCLES) @(posedge rvvi);
      @(negedge rvvi);
      rst_n_i = 1'b1;

      // Drive on the falling edge, check at the next falling edge
      for (int i = 0; i < name_q.size(); i++) begin
         cur_name   = name_q[i];
         row_errors = 0;
         drive_row(i);
         predict_row(i);
         @(negedge rvvi);
         check_row(i);
         if (row_errors == 0) begin
            pass_count++;
            $display("[ok]  %s", cur_name);
         end else begin
            fail_count++;
            $display("[err] %s, %0d wrong values", cur_name, row_errors);
         end
      end

      $display("%0d tests run, %0d passed, %0d failed", name_q.size(), pass_count, fail_count);
      if (fail_count == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // Table length plus reset plus margin
   initial begin : watchdog
      #1;
      #((name_q.size() + RST_CYCLES + 20) * CLK_PERIOD);
      $display("Watchdog expired before the table finished");
      $display("TEST FAILED");
      $finish;
   end

endmodule
